//--- files.f
src/spi_pkg.sv
src/spi_sclk_gen.sv
src/spi_shifter.sv
src/spi_cmd_fsm.sv
src/spi_master_top.sv
verification/spi_slave_model.sv
verification/spi_tb.sv

//--- verification/spi_tb.sv
module spi_tb;

  import spi_pkg::*;

  localparam int CLK_PERIOD     = 40;
  localparam int RAND_SEED      = 65;
  localparam int NUM_RANDOM     = 30;
  localparam int NUM_CMDS       = 40;  // ten directed plus the random mix
  localparam int CYCLES_PER_CMD = 250; // a read with its gap needs just under 200
  localparam int TIMEOUT_CYCLES = NUM_CMDS * CYCLES_PER_CMD + 2000;

  logic                  clk;
  logic                  rst_n;
  spi_cmd_u              cmd_in;
  logic                  cmd_vld;
  logic                  cmd_rdy;
  spi_pins_t             spi;
  logic                  miso;
  logic                  read_vld;
  logic [READ_WIDTH-1:0] read_data;

  logic [READ_WIDTH-1:0] ref_regs [0:(1<<ADDR_BITS)-1];
  spi_cmd_u              sent_q [$];
  logic [READ_WIDTH-1:0] exp_rd_q [$];
  logic [READ_WIDTH-1:0] exp_byte;
  int                    mismatch_errs;
  int                    other_errs;
  int                    cycle_cnt;

  spi_master_top i_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .spi       (spi),
    .miso      (miso),
    .read_vld  (read_vld),
    .read_data (read_data)
  );

  spi_slave_model #(.CLK_PERIOD(CLK_PERIOD)) i_slave (
    .spi  (spi),
    .miso (miso)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic spi_cmd_u make_cmd(input logic rw, input logic [ADDR_BITS-1:0] addr,
                                        input logic [READ_WIDTH-1:0] data);
    spi_cmd_u cmd;
    cmd.wr.rw   = rw;
    cmd.wr.addr = addr;
    cmd.wr.data = data;
    return cmd;
  endfunction

  // shadow register file, a write updates it and a read returns its content
  function automatic logic [READ_WIDTH-1:0] expected_read(input spi_cmd_u cmd);
    if (cmd.wr.rw)
    begin
      ref_regs[cmd.wr.addr] = cmd.wr.data;
      return '0;
    end
    return ref_regs[cmd.rd.addr];
  endfunction

  task automatic finish_run(input logic timed_out);
    if (timed_out)
    begin
      other_errs++;
      $display("timeout: the run did not complete within %0d cycles", TIMEOUT_CYCLES);
    end
    $display("summary: %0d mismatches, %0d other errors", mismatch_errs, other_errs);
    if (mismatch_errs + other_errs == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  endtask

  // holds the command until the handshake completes
  task automatic send_cmd(input spi_cmd_u cmd, input int unsigned idle_cycles);
    repeat (idle_cycles)
    begin
      @(posedge clk);
      #2;
    end
    cmd_in  = cmd;
    cmd_vld = 1'b1;
    @(posedge clk);
    while (!cmd_rdy)
    begin
      @(posedge clk);
    end
    sent_q.push_back(cmd);
    exp_byte = expected_read(cmd);
    if (!cmd.rd.rw)
      exp_rd_q.push_back(exp_byte);
    #2;
    cmd_vld = 1'b0;
    cmd_in  = CMD_WIDTH'($urandom); // the master must ignore cmd_in while cmd_vld is low
  endtask

  task automatic wait_idle();
    @(posedge clk);
    while (!cmd_rdy)
    begin
      @(posedge clk);
    end
    #2;
  endtask

  // walks the frames seen by the slave against the accepted commands in order
  task automatic check_frames();
    spi_cmd_u    cmd;
    logic [15:0] frame;
    logic [15:0] want;
    int          gap;
    while (sent_q.size() > 0)
    begin
      cmd = sent_q.pop_front();
      if (cmd.wr.rw)
        want = {4'(CMD_WIDTH), cmd};
      else
        want = {4'(ADDR_BITS + 1), 8'h00, 1'b0, cmd.rd.addr};
      if (i_slave.frame_log.size() == 0)
      begin
        other_errs++;
        $display("no SPI frame reached the slave for command %h", cmd);
        continue;
      end
      frame = i_slave.frame_log.pop_front();
      assert (frame == want)
      else
      begin
        mismatch_errs++;
        $display("mismatch at %0t: slave frame %h, expected %h", $time, frame, want);
      end
      if (!cmd.rd.rw)
      begin
        if (i_slave.frame_log.size() == 0 || i_slave.gap_log.size() == 0)
        begin
          other_errs++;
          $display("read of address %0d was not followed by a data frame", cmd.rd.addr);
          continue;
        end
        frame = i_slave.frame_log.pop_front();
        gap   = i_slave.gap_log.pop_front();
        assert (frame == {4'(READ_WIDTH), 12'h000})
        else
        begin
          mismatch_errs++;
          $display("mismatch at %0t: read data frame %h, expected 8 bits of zero", $time, frame);
        end
        assert (gap == GAP_CYCLES)
        else
        begin
          mismatch_errs++;
          $display("mismatch at %0t: cs gap %0d cycles, expected %0d", $time, gap, GAP_CYCLES);
        end
      end
    end
    if (i_slave.frame_log.size() != 0)
    begin
      other_errs++;
      $display("slave saw %0d frames with no accepted command", i_slave.frame_log.size());
    end
  endtask

  always @(posedge clk)
  begin
    if (rst_n && read_vld)
    begin
      if (exp_rd_q.size() == 0)
      begin
        other_errs++;
        $display("read_vld pulsed at %0t with no read outstanding", $time);
      end
      else
      begin
        exp_byte = exp_rd_q.pop_front();
        assert (read_data == exp_byte)
        else
        begin
          mismatch_errs++;
          $display("mismatch at %0t: read_data %h, expected %h", $time, read_data, exp_byte);
        end
      end
    end
  end

  always @(posedge clk)
  begin
    cycle_cnt++;
    if (cycle_cnt == TIMEOUT_CYCLES)
      finish_run(1'b1);
  end

  initial
  begin
    int       i;
    spi_cmd_u rnd_cmd;
    void'($urandom(RAND_SEED));
    clk           = 1'b0;
    rst_n         = 1'b0;
    cmd_vld       = 1'b0;
    cmd_in        = '0;
    mismatch_errs = 0;
    other_errs    = 0;
    cycle_cnt     = 0;
    for (i = 0; i < (1 << ADDR_BITS); i++)
    begin
      ref_regs[i] = READ_WIDTH'(8'hA0 + i);
    end
    repeat (5) @(posedge clk);
    #2;
    rst_n = 1'b1;
    @(posedge clk);
    #2;
    assert (cmd_rdy === 1'b1 && spi.cs === 1'b1 && spi.sclk === 1'b0 && read_vld === 1'b0)
    else
    begin
      mismatch_errs++;
      $display("mismatch at %0t: after reset cmd_rdy=%b cs=%b sclk=%b read_vld=%b",
               $time, cmd_rdy, spi.cs, spi.sclk, read_vld);
    end

    send_cmd(make_cmd(1'b1, 3'd1, 8'h5A), 1);
    send_cmd(make_cmd(1'b1, 3'd3, 8'hC3), 1);
    send_cmd(make_cmd(1'b1, 3'd6, 8'h0F), 1);
    send_cmd(make_cmd(1'b1, 3'd7, 8'hF0), 1);
    wait_idle();
    check_frames();

    // data bits of a read are junk on purpose, only flag and address go out
    send_cmd(make_cmd(1'b0, 3'd0, 8'h3C), 1);
    send_cmd(make_cmd(1'b0, 3'd2, 8'hFF), 1);
    send_cmd(make_cmd(1'b0, 3'd5, 8'h81), 1);
    send_cmd(make_cmd(1'b0, 3'd1, 8'h00), 1);
    send_cmd(make_cmd(1'b0, 3'd3, 8'h00), 1);
    send_cmd(make_cmd(1'b0, 3'd6, 8'h00), 1);
    wait_idle();
    check_frames();

    for (i = 0; i < NUM_RANDOM; i++)
    begin
      rnd_cmd = CMD_WIDTH'($urandom);
      send_cmd(rnd_cmd, $urandom % 8); // short idle often raises cmd_vld while busy
    end
    wait_idle();
    check_frames();
    if (exp_rd_q.size() != 0)
    begin
      other_errs++;
      $display("%0d accepted reads never produced a read_vld pulse", exp_rd_q.size());
    end
    finish_run(1'b0);
  end

endmodule

//--- verification/spi_slave_model.sv
module spi_slave_model #(
  parameter int CLK_PERIOD = 40
) (
  input  spi_pkg::spi_pins_t spi,
  output logic               miso
);

  import spi_pkg::*;

  logic [READ_WIDTH-1:0] regs [0:(1<<ADDR_BITS)-1];
  logic [CMD_WIDTH-1:0]  rx_sr;
  logic [READ_WIDTH-1:0] tx_sr;
  logic [ADDR_BITS-1:0]  rd_addr;
  logic                  gap_open;
  logic                  rd_active;
  int                    bit_cnt;
  time                   cs_rise_t;

  // every finished frame as {bit count, received bits}, oldest first
  logic [15:0] frame_log [$];
  int          gap_log [$]; // cs high time before each read data frame, in clk cycles

  initial
  begin
    int i;
    for (i = 0; i < (1 << ADDR_BITS); i++)
    begin
      regs[i] = READ_WIDTH'(8'hA0 + i);
    end
    rx_sr     = '0;
    tx_sr     = '0;
    rd_addr   = '0;
    gap_open  = 1'b0;
    rd_active = 1'b0;
    bit_cnt   = 0;
    cs_rise_t = 0;
    miso      = 1'b0;
  end

  always @(negedge spi.cs)
  begin
    bit_cnt = 0;
    rx_sr   = '0;
    if (gap_open)
    begin
      gap_log.push_back(int'(($time - cs_rise_t) / CLK_PERIOD));
      gap_open  = 1'b0;
      rd_active = 1'b1;
      tx_sr     = regs[rd_addr];
      miso      = tx_sr[READ_WIDTH-1]; // first bit waits on the line for the first rise
    end
  end

  always @(posedge spi.sclk)
  begin
    if (!spi.cs)
    begin
      rx_sr   = {rx_sr[CMD_WIDTH-2:0], spi.mosi};
      bit_cnt = bit_cnt + 1;
    end
  end

  always @(negedge spi.sclk)
  begin
    if (rd_active && !spi.cs)
    begin
      tx_sr = tx_sr << 1;
      miso  = tx_sr[READ_WIDTH-1];
    end
  end

  always @(posedge spi.cs)
  begin
    if (bit_cnt != 0)
    begin
      frame_log.push_back({4'(bit_cnt), rx_sr});
      if (bit_cnt == CMD_WIDTH && rx_sr[CMD_WIDTH-1])
        regs[rx_sr[CMD_WIDTH-2 -: ADDR_BITS]] = rx_sr[READ_WIDTH-1:0];
      else if (bit_cnt == ADDR_BITS + 1)
      begin
        // short frame carries flag and address, the data frame follows after the gap
        rd_addr   = rx_sr[ADDR_BITS-1:0];
        gap_open  = 1'b1;
        cs_rise_t = $time;
      end
    end
    bit_cnt   = 0;
    rd_active = 1'b0;
    miso      = 1'b0;
  end

endmodule

//--- src/spi_master_top.sv
module spi_master_top (
  input  logic                            clk,
  input  logic                            rst_n,
  input  spi_pkg::spi_cmd_u               cmd_in,
  input  logic                            cmd_vld,
  output logic                            cmd_rdy,
  output spi_pkg::spi_pins_t              spi,
  input  logic                            miso,
  output logic                            read_vld,
  output logic [spi_pkg::READ_WIDTH-1:0]  read_data
);

  import spi_pkg::*;

  logic                  sclk_en;
  logic                  sclk;
  logic                  cs;
  logic                  mosi;
  logic                  load;
  spi_cmd_u              load_word;
  sclk_edge_t            sclk_edge;
  logic [READ_WIDTH-1:0] rx_byte;

  spi_cmd_fsm i_cmd_fsm (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .sclk_en   (sclk_en),
    .sclk_edge (sclk_edge),
    .cs        (cs),
    .load      (load),
    .load_word (load_word),
    .rx_byte   (rx_byte),
    .read_vld  (read_vld),
    .read_data (read_data)
  );

  spi_sclk_gen i_sclk_gen (
    .clk       (clk),
    .rst_n     (rst_n),
    .sclk_en   (sclk_en),
    .sclk_edge (sclk_edge),
    .sclk      (sclk)
  );

  spi_shifter i_shifter (
    .clk       (clk),
    .rst_n     (rst_n),
    .load      (load),
    .load_word (load_word),
    .sclk_edge (sclk_edge),
    .miso      (miso),
    .mosi      (mosi),
    .rx_byte   (rx_byte)
  );

  assign spi = '{sclk: sclk, cs: cs, mosi: mosi};

endmodule

//--- src/spi_cmd_fsm.sv
module spi_cmd_fsm (
  input  logic                            clk,
  input  logic                            rst_n,
  input  spi_pkg::spi_cmd_u               cmd_in,
  input  logic                            cmd_vld,
  output logic                            cmd_rdy,
  output logic                            sclk_en,
  input  spi_pkg::sclk_edge_t             sclk_edge,
  output logic                            cs,
  output logic                            load,
  output spi_pkg::spi_cmd_u               load_word,
  input  logic [spi_pkg::READ_WIDTH-1:0]  rx_byte,
  output logic                            read_vld,
  output logic [spi_pkg::READ_WIDTH-1:0]  read_data
);

  import spi_pkg::*;

  spi_state_e           state;
  spi_state_e           state_nxt;
  spi_cmd_u             cmd_q;
  logic [BIT_CNT_W-1:0] bit_cnt;
  logic [BIT_CNT_W-1:0] bit_target;
  logic [WAIT_W-1:0]    wait_cnt;
  logic                 frame_st;
  logic                 bits_done;
  logic                 tail_done;
  logic                 gap_done;
  logic                 accept;

  assign cmd_rdy = (state == st_idle);
  assign accept  = cmd_vld && cmd_rdy;

  assign frame_st = (state == st_write_frame) || (state == st_read_addr) ||
                    (state == st_read_data);

  always_comb
  begin
    case (state)
      st_write_frame: bit_target = BIT_CNT_W'(CMD_WIDTH);
      st_read_addr:   bit_target = BIT_CNT_W'(ADDR_BITS + 1); // flag plus address
      st_read_data:   bit_target = BIT_CNT_W'(READ_WIDTH);
      default:        bit_target = '0;
    endcase
  end

  assign bits_done = frame_st && (bit_cnt == bit_target);

  // after the last rise, hold cs low until sclk has dropped again
  assign tail_done = bits_done && (wait_cnt == WAIT_W'(SCLK_HALF - 2));
  assign gap_done  = (state == st_read_gap) && (wait_cnt == WAIT_W'(GAP_CYCLES - 1));

  always_comb
  begin
    state_nxt = state;
    case (state)
      st_idle:
      begin
        if (cmd_vld)
        begin
          state_nxt = cmd_in.wr.rw ? st_write_frame : st_read_addr;
        end
      end
      st_write_frame, st_read_data:
      begin
        if (tail_done)
        begin
          state_nxt = st_finish;
        end
      end
      st_read_addr:
      begin
        if (tail_done)
        begin
          state_nxt = st_read_gap;
        end
      end
      st_read_gap:
      begin
        if (gap_done)
        begin
          state_nxt = st_read_data;
        end
      end
      st_finish: state_nxt = st_idle;
      default:   state_nxt = st_idle;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state <= st_idle;
    end
    else
    begin
      state <= state_nxt;
    end
  end

  // both counters restart on every state change
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      bit_cnt  <= '0;
      wait_cnt <= '0;
    end
    else if (state_nxt != state)
    begin
      bit_cnt  <= '0;
      wait_cnt <= '0;
    end
    else
    begin
      if (frame_st && sclk_edge.rise)
      begin
        bit_cnt <= bit_cnt + 1'b1;
      end
      if (bits_done || state == st_read_gap)
      begin
        wait_cnt <= wait_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      cmd_q <= cmd_in;
    end
  end

  // the data frame is reloaded with zeros so mosi stays low while miso comes in
  assign load      = accept || gap_done;
  assign load_word = cmd_rdy ? cmd_in : '0;

  assign sclk_en = frame_st;
  assign cs      = ~frame_st;

  always_ff @(posedge clk)
  begin
    if (tail_done && state == st_read_data)
    begin
      read_data <= rx_byte;
    end
  end

  assign read_vld = (state == st_finish) && !cmd_q.rd.rw;

  a_rdy_not_in_frame: assert property (
    @(posedge clk) disable iff (!rst_n)
    !(cmd_rdy && !cs)
  );

  a_read_vld_pulse: assert property (
    @(posedge clk) disable iff (!rst_n)
    read_vld |=> !read_vld
  );

endmodule

//--- src/spi_shifter.sv
module spi_shifter (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            load,
  input  spi_pkg::spi_cmd_u               load_word,
  input  spi_pkg::sclk_edge_t             sclk_edge,
  input  logic                            miso,
  output logic                            mosi,
  output logic [spi_pkg::READ_WIDTH-1:0]  rx_byte
);

  import spi_pkg::*;

  logic [CMD_WIDTH-1:0]  tx_q;
  logic [READ_WIDTH-1:0] rx_q;

  // word sits left aligned so the msb leaves first
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      tx_q <= '0; // keeps mosi low out of reset
    end
    else if (load)
    begin
      tx_q <= load_word;
    end
    else if (sclk_edge.fall)
    begin
      tx_q <= {tx_q[CMD_WIDTH-2:0], 1'b0};
    end
  end

  assign mosi = tx_q[CMD_WIDTH-1];

  // the slave changes miso on the falling edge so it is stable at the rise
  always_ff @(posedge clk)
  begin
    if (sclk_edge.rise)
    begin
      rx_q <= {rx_q[READ_WIDTH-2:0], miso};
    end
  end

  assign rx_byte = rx_q;

  // the fsm only loads while sclk is parked
  a_load_no_edge: assert property (
    @(posedge clk) disable iff (!rst_n)
    load |-> !(sclk_edge.rise || sclk_edge.fall)
  );

endmodule

//--- src/spi_sclk_gen.sv
module spi_sclk_gen (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   sclk_en,
  output spi_pkg::sclk_edge_t    sclk_edge,
  output logic                   sclk
);

  import spi_pkg::*;

  logic [DIV_W-1:0] div_cnt;
  logic             half_done;

  assign half_done = (div_cnt == DIV_W'(SCLK_HALF - 1));

  // strobes are registered so they line up with the new sclk level
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      div_cnt   <= '0;
      sclk      <= 1'b0;
      sclk_edge <= '0;
    end
    else if (!sclk_en)
    begin
      // every frame restarts from the same phase
      div_cnt   <= '0;
      sclk      <= 1'b0;
      sclk_edge <= '0;
    end
    else
    begin
      sclk_edge <= '0;
      if (half_done)
      begin
        div_cnt        <= '0;
        sclk           <= ~sclk;
        sclk_edge.rise <= ~sclk; // going high
        sclk_edge.fall <= sclk;
      end
      else
      begin
        div_cnt <= div_cnt + 1'b1;
      end
    end
  end

  a_edge_exclusive: assert property (
    @(posedge clk) disable iff (!rst_n)
    !(sclk_edge.rise && sclk_edge.fall)
  );

  // a fall follows every rise half a period later unless the frame was cut
  a_half_period: assert property (
    @(posedge clk) disable iff (!rst_n)
    sclk_edge.rise |-> ##SCLK_HALF (sclk_edge.fall || !sclk_en)
  );

endmodule

//--- src/spi_pkg.sv
package spi_pkg;

  localparam int CMD_WIDTH  = 12;
  localparam int READ_WIDTH = 8;
  localparam int ADDR_BITS  = 3;
  localparam int SCLK_HALF  = 4;   // clk cycles per sclk half period
  localparam int GAP_CYCLES = 100; // cs high time between the two read frames

  localparam int DIV_W     = $clog2(SCLK_HALF);
  localparam int BIT_CNT_W = $clog2(CMD_WIDTH + 1);
  localparam int WAIT_W    = $clog2(GAP_CYCLES);

  typedef struct packed {
    logic                  rw;
    logic [ADDR_BITS-1:0]  addr;
    logic [READ_WIDTH-1:0] data;
  } spi_wr_cmd_t;

  // only the top four bits leave the master on a read
  typedef struct packed {
    logic                  rw;
    logic [ADDR_BITS-1:0]  addr;
    logic [READ_WIDTH-1:0] unused;
  } spi_rd_cmd_t;

  typedef union packed {
    spi_wr_cmd_t wr;
    spi_rd_cmd_t rd;
  } spi_cmd_u;

  typedef struct packed {
    logic sclk;
    logic cs;
    logic mosi;
  } spi_pins_t;

  typedef struct packed {
    logic rise;
    logic fall;
  } sclk_edge_t;

  typedef enum logic [2:0] {
    st_idle,
    st_write_frame,
    st_read_addr,
    st_read_gap,
    st_read_data,
    st_finish
  } spi_state_e;

endpackage
